//--- files.f
source/vuad_pkg.sv
source/vuad_addr_ctl.sv
source/vuad_subarray.sv
source/vuad_read_mux.sv
source/vuad_array.sv
sim/vuad_assertions.sv
sim/vuad_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the vuad testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module vuad_tb -o vuad_sim
./obj_dir/vuad_sim | tee sim.log

if grep -q "\*\* FAIL \*\*" sim.log; then
   echo "simulation failed, see sim.log"
   exit 1
fi
echo "simulation passed"

//--- sim/vuad_tb.sv
`timescale 1ns/100ps
`default_nettype none

module vuad_tb
   import vuad_pkg::*;
();

   localparam int HALF_W     = 12;
   localparam int WORD_W     = 2 * HALF_W;
   localparam int MAX_CYCLES = 6000; // about 2900 used

   logic              rclk;
   logic              arst_n;
   vuad_index_t       rd_addr1;
   vuad_index_t       rd_addr2;
   logic              rd_addr_sel;
   logic              array_rd_en;
   vuad_index_t       wr_addr;
   logic              wr_en0;
   logic              wr_en1;
   logic [WORD_W-1:0] wr_data;
   logic [WORD_W-1:0] rd_data;

   logic [WORD_W-1:0] model [1024]; // reference copy of the array
   logic [WORD_W-1:0] last_read;    // what rd_data must hold
   logic [31:0]       lcg_state;
   int                errors;
   int                checks;
   int                cycles = 0;

   vuad_array #(.HALF_W(HALF_W)) i_vuad_array (
      .rclk        (rclk),
      .arst_n      (arst_n),
      .rd_addr1    (rd_addr1),
      .rd_addr2    (rd_addr2),
      .rd_addr_sel (rd_addr_sel),
      .array_rd_en (array_rd_en),
      .wr_addr     (wr_addr),
      .wr_en0      (wr_en0),
      .wr_en1      (wr_en1),
      .wr_data     (wr_data),
      .rd_data     (rd_data)
   );

   initial begin
      rclk = 1'b0;
      forever #2 rclk = ~rclk;
   end

   always @(posedge rclk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
         $display("** FAIL **");
         $finish;
      end
   end

   //////////////////////////////
   // helpers
   //////////////////////////////

   function automatic logic [31:0] rand_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // upper bits only, the low lcg bits repeat fast
   function automatic vuad_index_t rand_index();
      return vuad_index_t'(rand_next() >> 22);
   endfunction

   function automatic logic [WORD_W-1:0] rand_word();
      return WORD_W'(rand_next() >> 8);
   endfunction

   task automatic check_value(input string name, input logic [WORD_W-1:0] actual,
                              input logic [WORD_W-1:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, actual, expected);
      end
   endtask

   // one clock of stimulus, rd_data checked after the edge
   task automatic run_cycle(input vuad_index_t waddr, input logic [1:0] wen,
                            input logic [WORD_W-1:0] wdata, input logic ren,
                            input vuad_index_t raddr1, input vuad_index_t raddr2,
                            input logic sel);
      vuad_index_t raddr;
      raddr = sel ? raddr1 : raddr2;
      if (ren) last_read = model[raddr]; // taken before this cycle's write
      wr_addr     = waddr;
      wr_en0      = wen[0];
      wr_en1      = wen[1];
      wr_data     = wdata;
      array_rd_en = ren;
      rd_addr1    = raddr1;
      rd_addr2    = raddr2;
      rd_addr_sel = sel;
      if (wen[0]) model[waddr][HALF_W-1:0] = wdata[HALF_W-1:0];      // vd
      if (wen[1]) model[waddr][WORD_W-1:HALF_W] = wdata[WORD_W-1:HALF_W]; // ua
      @(posedge rclk);
      #1;
      check_value("rd_data", rd_data, last_read);
   endtask

   task automatic end_test(input string name, input int errors_before);
      $display("test %s finished, %0d errors", name, errors - errors_before);
   endtask

   //////////////////////////////
   // tests
   //////////////////////////////

   task automatic test_fill();
      int err0;
      err0 = errors;
      for (int i = 0; i < 1024; i++) run_cycle(vuad_index_t'(i), 2'b11, rand_word(),
                                               1'b0, '0, '0, 1'b0);
      for (int i = 0; i < 1024; i++) run_cycle('0, 2'b00, '0, 1'b1, vuad_index_t'(i),
                                               rand_index(), 1'b1);
      end_test("fill", err0);
   endtask

   task automatic test_half_write();
      int          err0;
      vuad_index_t idx;
      err0 = errors;
      for (int n = 0; n < 16; n++) begin
         idx = rand_index();
         run_cycle(idx, 2'b01, rand_word(), 1'b0, '0, '0, 1'b0); // vd only
         run_cycle('0, 2'b00, '0, 1'b1, idx, '0, 1'b1);
         run_cycle(idx, 2'b10, rand_word(), 1'b0, '0, '0, 1'b0); // ua only
         run_cycle('0, 2'b00, '0, 1'b1, '0, idx, 1'b0);
      end
      end_test("half_write", err0);
   endtask

   task automatic test_addr_sel();
      int          err0;
      vuad_index_t a1;
      err0 = errors;
      for (int n = 0; n < 16; n++) begin
         a1 = rand_index();
         run_cycle('0, 2'b00, '0, 1'b1, a1, a1 ^ 10'h2a5, 1'b0); // returns addr2 entry
         run_cycle('0, 2'b00, '0, 1'b1, a1, a1 ^ 10'h2a5, 1'b1);
      end
      end_test("addr_sel", err0);
   endtask

   task automatic test_word_isolation();
      int          err0;
      vuad_row_t   row;
      vuad_index_t idx;
      err0 = errors;
      for (int s = 0; s < 8; s++) begin
         row = vuad_row_t'(rand_next() >> 27);
         for (int w = 0; w < 4; w++) begin
            idx = {3'(s), row, 2'(w)};
            run_cycle(idx, 2'b11, rand_word(), 1'b0, '0, '0, 1'b0);
            // every word of the row, the neighbors too
            for (int v = 0; v < 4; v++) begin
               idx = {3'(s), row, 2'(v)};
               run_cycle('0, 2'b00, '0, 1'b1, idx, '0, 1'b1);
            end
         end
      end
      end_test("word_isolation", err0);
   endtask

   task automatic test_hold();
      int err0;
      err0 = errors;
      for (int n = 0; n < 4; n++) begin
         run_cycle('0, 2'b00, '0, 1'b1, rand_index(), '0, 1'b1);
         for (int m = 0; m < 8; m++) run_cycle(rand_index(), 2'b00, rand_word(), 1'b0,
                                               rand_index(), rand_index(), 1'(m));
      end
      end_test("hold", err0);
   endtask

   task automatic test_random_mix();
      int          err0;
      logic [31:0] r;
      vuad_index_t waddr;
      vuad_index_t a1;
      vuad_index_t a2;
      logic        ren;
      err0 = errors;
      for (int n = 0; n < 500; n++) begin
         r     = rand_next();
         waddr = rand_index();
         a1    = rand_index();
         a2    = rand_index();
         ren   = r[29];
         if (r[27:26] == 2'b00) begin // same entry written and read
            a1  = waddr;
            a2  = waddr;
            ren = 1'b1;
         end
         run_cycle(waddr, r[31:30], rand_word(), ren, a1, a2, r[28]);
      end
      end_test("random_mix", err0);
   endtask

   initial begin
      lcg_state   = 32'd1010;
      errors      = 0;
      checks      = 0;
      last_read   = '0;
      arst_n      = 1'b0;
      rd_addr1    = '0;
      rd_addr2    = '0;
      rd_addr_sel = 1'b0;
      array_rd_en = 1'b0;
      wr_addr     = '0;
      wr_en0      = 1'b0;
      wr_en1      = 1'b0;
      wr_data     = '0;
      repeat (5) @(posedge rclk);
      #1;
      arst_n = 1'b1;
      test_fill();
      test_half_write();
      test_addr_sel();
      test_word_isolation();
      test_hold();
      test_random_mix();
      $display("done: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sim/vuad_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module vuad_assertions
   import vuad_pkg::*;
(
   input wire          rclk,
   input wire          arst_n,
   input wire          array_rd_en,
   input vuad_wr_ctl_t wr_ctl,
   input vuad_sub_en_t rd_en,
   input vuad_rd_sel_t rd_sel
);

   logic read_seen; // selects stay zero until the first read

   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         read_seen <= 1'b0;
      end else if (array_rd_en) begin
         read_seen <= 1'b1;
      end
   end

   a_wr_col_en: assert property (@(posedge rclk) disable iff (!arst_n)
      $onehot0(wr_ctl.en_c0) && $onehot0(wr_ctl.en_c1))
      else $error("column write enable set in more than one subarray");

   // four even or four odd subarrays
   a_rd_en_half: assert property (@(posedge rclk) disable iff (!arst_n)
      array_rd_en |-> (rd_en == 8'h55 || rd_en == 8'haa))
      else $error("read enable not steered to one half of the subarrays");

   a_rd_sel_onehot: assert property (@(posedge rclk) disable iff (!arst_n)
      read_seen |-> ($onehot(rd_sel.word_sel) && $onehot(rd_sel.pair_sel)))
      else $error("registered word or pair select is not one-hot");

endmodule

bind vuad_addr_ctl vuad_assertions i_vuad_assertions (
   .rclk        (rclk),
   .arst_n      (arst_n),
   .array_rd_en (array_rd_en),
   .wr_ctl      (wr_ctl),
   .rd_en       (rd_en),
   .rd_sel      (rd_sel)
);

`default_nettype wire

//--- source/vuad_array.sv
`timescale 1ns/100ps
`default_nettype none

module vuad_array
   import vuad_pkg::*;
#(
   parameter int HALF_W = 12
) (
   input  wire                 rclk,
   input  wire                 arst_n,
   input  vuad_index_t         rd_addr1,
   input  vuad_index_t         rd_addr2,
   input  wire                 rd_addr_sel,
   input  wire                 array_rd_en,
   input  vuad_index_t         wr_addr,
   input  wire                 wr_en0,
   input  wire                 wr_en1,
   input  wire [2*HALF_W-1:0]  wr_data,
   output logic [2*HALF_W-1:0] rd_data
);

   vuad_wr_ctl_t                 wr_ctl;
   vuad_row_t                    rd_row1;
   vuad_row_t                    rd_row2;
   logic                         rd_row_sel;
   vuad_sub_en_t                 rd_en;
   vuad_rd_sel_t                 rd_sel;
   logic [7:0][3:0][2*HALF_W-1:0] rows; // registered row of each subarray

   vuad_addr_ctl i_addr_ctl (
      .rclk        (rclk),
      .arst_n      (arst_n),
      .rd_addr1    (rd_addr1),
      .rd_addr2    (rd_addr2),
      .rd_addr_sel (rd_addr_sel),
      .array_rd_en (array_rd_en),
      .wr_addr     (wr_addr),
      .wr_en0      (wr_en0),
      .wr_en1      (wr_en1),
      .wr_ctl      (wr_ctl),
      .rd_row1     (rd_row1),
      .rd_row2     (rd_row2),
      .rd_row_sel  (rd_row_sel),
      .rd_en       (rd_en),
      .rd_sel      (rd_sel)
   );

   // each subarray takes its own enable bits, the rest is shared
   for (genvar s = 0; s < 8; s++) begin : g_sub
      vuad_subarray #(.HALF_W(HALF_W)) i_subarray (
         .rclk        (rclk),
         .arst_n      (arst_n),
         .rd_row1     (rd_row1),
         .rd_row2     (rd_row2),
         .rd_row_sel  (rd_row_sel),
         .rd_en       (rd_en[s]),
         .wr_row      (wr_ctl.row),
         .wr_word_en  (wr_ctl.word_en),
         .wr_en_c0    (wr_ctl.en_c0[s]),
         .wr_en_c1    (wr_ctl.en_c1[s]),
         .wr_data     (wr_data),
         .rd_data_row (rows[s])
      );
   end

   vuad_read_mux #(.HALF_W(HALF_W)) i_read_mux (
      .rows    (rows),
      .rd_sel  (rd_sel),
      .rd_data (rd_data)
   );

endmodule

`default_nettype wire

//--- source/vuad_read_mux.sv
`timescale 1ns/100ps
`default_nettype none

module vuad_read_mux
   import vuad_pkg::*;
#(
   parameter int HALF_W = 12
) (
   input  wire [7:0][3:0][2*HALF_W-1:0] rows,
   input  vuad_rd_sel_t                 rd_sel,
   output logic [2*HALF_W-1:0]          rd_data
);

   localparam int WORD_W = 2 * HALF_W;

   logic [7:0][WORD_W-1:0] sub_word;  // one word from each subarray
   logic [3:0][WORD_W-1:0] pair_word; // even or odd word of each pair

   //////////////////////////////
   // word within the row
   //////////////////////////////

   // and-or mux, all zero while word_sel is zero
   always_comb begin
      for (int s = 0; s < 8; s++) begin
         sub_word[s] = '0;
         for (int w = 0; w < 4; w++) begin
            sub_word[s] = sub_word[s] | ({WORD_W{rd_sel.word_sel[w]}} & rows[s][w]);
         end
      end
   end

   //////////////////////////////
   // even/odd, then pair
   //////////////////////////////

   always_comb begin
      for (int p = 0; p < 4; p++) begin
         pair_word[p] = rd_sel.odd_sel ? sub_word[2*p+1] : sub_word[2*p];
      end
   end

   always_comb begin
      rd_data = '0;
      for (int p = 0; p < 4; p++) begin
         rd_data = rd_data | ({WORD_W{rd_sel.pair_sel[p]}} & pair_word[p]);
      end
   end

endmodule

`default_nettype wire

//--- source/vuad_subarray.sv
`timescale 1ns/100ps
`default_nettype none

module vuad_subarray
   import vuad_pkg::*;
#(
   parameter int HALF_W = 12
) (
   input  wire                             rclk,
   input  wire                             arst_n,
   input  vuad_row_t                       rd_row1,
   input  vuad_row_t                       rd_row2,
   input  wire                             rd_row_sel,
   input  wire                             rd_en,
   input  vuad_row_t                       wr_row,
   input  vuad_word_en_t                   wr_word_en,
   input  wire                             wr_en_c0,
   input  wire                             wr_en_c1,
   input  wire [2*HALF_W-1:0]              wr_data,
   output logic [3:0][2*HALF_W-1:0]        rd_data_row
);

   localparam int WORD_W = 2 * HALF_W;

   logic [3:0][WORD_W-1:0] mem [32]; // 32 rows of 4 words
   vuad_row_t              rd_row;

   // write the enabled half of the enabled word
   always_ff @(posedge rclk) begin
      for (int w = 0; w < 4; w++) begin
         if (wr_word_en[w] && wr_en_c0) begin
            mem[wr_row][w][HALF_W-1:0] <= wr_data[HALF_W-1:0]; // vd
         end
         if (wr_word_en[w] && wr_en_c1) begin
            mem[wr_row][w][WORD_W-1:HALF_W] <= wr_data[WORD_W-1:HALF_W]; // ua
         end
      end
   end

   //////////////////////////////
   // row read
   //////////////////////////////

   assign rd_row = rd_row_sel ? rd_row1 : rd_row2;

   // a same-cycle write is not seen here, old data is read
   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         rd_data_row <= '0;
      end else if (rd_en) begin
         rd_data_row <= mem[rd_row];
      end
   end

endmodule

`default_nettype wire

//--- source/vuad_addr_ctl.sv
`timescale 1ns/100ps
`default_nettype none

module vuad_addr_ctl
   import vuad_pkg::*;
(
   input  wire           rclk,
   input  wire           arst_n,
   input  vuad_index_t   rd_addr1,
   input  vuad_index_t   rd_addr2,
   input  wire           rd_addr_sel,
   input  wire           array_rd_en,
   input  vuad_index_t   wr_addr,
   input  wire           wr_en0,
   input  wire           wr_en1,
   output vuad_wr_ctl_t  wr_ctl,
   output vuad_row_t     rd_row1,
   output vuad_row_t     rd_row2,
   output logic          rd_row_sel,
   output vuad_sub_en_t  rd_en,
   output vuad_rd_sel_t  rd_sel
);

   vuad_index_t  rd_addr;   // address picked for this read
   vuad_sub_en_t wr_sub;    // decoded bits 9:7 of the write index
   vuad_rd_sel_t rd_sel_nxt;

   //////////////////////////////
   // write decode
   //////////////////////////////

   always_comb begin
      wr_sub = vuad_sub_en_t'(1) << wr_addr[9:7];

      wr_ctl.row     = wr_addr[6:2];
      wr_ctl.word_en = vuad_word_en_t'(1) << wr_addr[1:0];
      wr_ctl.en_c0   = wr_sub & {8{wr_en0}};
      wr_ctl.en_c1   = wr_sub & {8{wr_en1}};
   end

   //////////////////////////////
   // read address and enables
   //////////////////////////////

   assign rd_addr = rd_addr_sel ? rd_addr1 : rd_addr2; // high picks addr1

   // subarrays pick their own row, only the row bits go out
   assign rd_row1    = rd_addr1[6:2];
   assign rd_row2    = rd_addr2[6:2];
   assign rd_row_sel = rd_addr_sel;

   // bit 7 steers the enable to the even or the odd half
   always_comb begin
      for (int s = 0; s < 8; s++) begin
         if (s % 2 == 0) begin
            rd_en[s] = array_rd_en & ~rd_addr[7];
         end else begin
            rd_en[s] = array_rd_en & rd_addr[7];
         end
      end
   end

   //////////////////////////////
   // second-cycle selects
   //////////////////////////////

   always_comb begin
      rd_sel_nxt.word_sel = vuad_word_en_t'(1) << rd_addr[1:0];
      rd_sel_nxt.odd_sel  = rd_addr[7];
      rd_sel_nxt.pair_sel = vuad_word_en_t'(1) << rd_addr[9:8];
   end

   // held between reads so rd_data stays put
   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         rd_sel <= '0;
      end else if (array_rd_en) begin
         rd_sel <= rd_sel_nxt;
      end
   end

endmodule

`default_nettype wire

//--- source/vuad_pkg.sv
`default_nettype none

package vuad_pkg;

   //////////////////////////////
   // index fields
   //////////////////////////////

   // 9:8 pair, 7 odd, 6:2 row, 1:0 word
   typedef logic [9:0] vuad_index_t;

   typedef logic [4:0] vuad_row_t;     // row inside one subarray
   typedef logic [3:0] vuad_word_en_t; // one-hot word in a row
   typedef logic [7:0] vuad_sub_en_t;  // one bit per subarray

   //////////////////////////////
   // write and read control
   //////////////////////////////

   // write decode, shared by all subarrays
   typedef struct packed {
      vuad_row_t     row;
      vuad_word_en_t word_en;
      vuad_sub_en_t  en_c0; // vd half
      vuad_sub_en_t  en_c1; // ua half
   } vuad_wr_ctl_t;

   // second-cycle read selects
   typedef struct packed {
      vuad_word_en_t word_sel; // one-hot word in a row
      logic          odd_sel;  // odd subarray of a pair
      vuad_word_en_t pair_sel; // one-hot subarray pair
   } vuad_rd_sel_t;

endpackage

`default_nettype wire
